// File: run.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decodeTb -f vlog.f \
	--Mdir obj_dir -o VdecodeTb

if ! ./obj_dir/VdecodeTb > sim.log 2>&1
then
	cat sim.log
	echo "Simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -q "STATUS: FAIL" sim.log
then
	exit 1
fi
echo "Simulation finished without failures"

// File: source/decodeBus.sv
`timescale 1ns/1ps

// Latched instruction out to the sub-decoders and their results back
interface decodeBus import quplsPkg::*; ();

	// Instruction held by the stage for the whole decode
	instruction_t instr;

	// Operand swap result
	logic swap;

	// Immediate results
	logic [31:0] imm;
	logic hasImm;

	// Register fields and class flags
	logic [4:0] rt;
	logic [4:0] ra;
	logic [4:0] rb;
	logic isLoad;
	logic isStore;
	logic writesRt;
	logic illegal;

	modport stage (output instr, input swap, imm, hasImm, rt, ra, rb,
		isLoad, isStore, writesRt, illegal);
	modport swapDec (input instr, output swap);
	modport immDec (input instr, output imm, hasImm);
	modport regDec (input instr, output rt, ra, rb, isLoad, isStore, writesRt, illegal);

endinterface

// File: source/decodeImm.sv
`timescale 1ns/1ps

// Immediate decoder
// Builds the 32 bit immediate from the upper instruction bits
module decodeImm import quplsPkg::*;
(
	decodeBus.immDec bus
);

	// ==============================
	// Field extraction
	// ==============================

	// Raw immediate with immHi on top and the rb bits below
	logic [IMM_BITS-1:0] immField;

	// Sign bit of the raw field which is instruction bit 31
	logic immSign;

	// Sign-extended value before qualification by opcode
	logic [31:0] immExt;

	// High when the opcode carries an immediate
	logic immForm;

	assign immField = {bus.instr.immHi, bus.instr.rb};
	assign immSign = immField[IMM_BITS-1];

	// Replicate the sign across the upper bits
	assign immExt = {{(32 - IMM_BITS){immSign}}, immField};

	// ==============================
	// Qualification
	// ==============================

	// Same opcode classes as the swap decoder
	assign immForm = fnImmForm(bus.instr.opcode);

	assign bus.hasImm = immForm;

	// Register forms reuse these bits as rb so the immediate reads as zero
	// Illegal codes fall out of fnImmForm and also give zero
	always_comb
	begin
		if (immForm)
			bus.imm = immExt;
		else
			bus.imm = 32'd0;
	end

endmodule

// File: source/decodeRegs.sv
`timescale 1ns/1ps

// Register field and class decoder
// Keeps only the register numbers that an opcode really uses
module decodeRegs import quplsPkg::*;
(
	decodeBus.regDec bus
);

	// Field enables chosen per opcode group
	logic useRa;
	logic useRb;

	always_comb
	begin
		// Defaults cover the immediate groups that only read ra
		useRa = 1'b1;
		useRb = 1'b0;
		bus.writesRt = 1'b0;
		bus.isLoad = 1'b0;
		bus.isStore = 1'b0;
		bus.illegal = 1'b0;
		case (bus.instr.opcode)
			// A no-op touches no register at all
			OP_NOP:
				useRa = 1'b0;
			OP_ADD, OP_SUB, OP_AND, OP_OR:
			begin
				useRb = 1'b1;
				bus.writesRt = 1'b1;
			end
			OP_ADDI, OP_MULI, OP_DIVI, OP_SUBFI, OP_ANDI, OP_ORI, OP_EORI, OP_JSR:
				bus.writesRt = 1'b1;
			// Compare only sets flags and has no target
			OP_CMPI:
				useRa = 1'b1;
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO:
			begin
				bus.isLoad = 1'b1;
				bus.writesRt = 1'b1;
			end
			// Cache control goes down the load path but returns nothing
			OP_CACHE:
				bus.isLoad = 1'b1;
			OP_STB, OP_STW, OP_STT, OP_STO:
				bus.isStore = 1'b1;
			// Anything outside the enum
			default:
			begin
				useRa = 1'b0;
				bus.illegal = 1'b1;
			end
		endcase
	end

	// Unused fields are forced to zero so the issue side sees no false hazards
	assign bus.ra = useRa ? bus.instr.ra : 5'd0;
	assign bus.rb = useRb ? bus.instr.rb : 5'd0;
	assign bus.rt = bus.writesRt ? bus.instr.rt : 5'd0;

endmodule

// File: source/decodeStage.sv
`timescale 1ns/1ps

// Decode stage with a four-phase handshake on each side
// One instruction is in flight at a time
module decodeStage import quplsPkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         inReq,
	output logic         inAck,
	input  instruction_t instr,
	output logic         outReq,
	input  logic         outAck,
	output decoded_t     decoded
);

	hsState_t state;

	// Set between the latch edge and the result edge while idle
	logic haveInstr;

	// Strobes for the payload registers
	logic loadInstr;
	logic loadResult;

	// Combined result of the three sub-decoders
	decoded_t decodeNow;

	decodeBus bus ();

	decodeSwap swapDec0 (.bus(bus.swapDec));
	decodeImm immDec0 (.bus(bus.immDec));
	decodeRegs regDec0 (.bus(bus.regDec));

	// ==============================
	// Handshake control
	// ==============================

	assign loadInstr = (state == S_IDLE) && !haveInstr && inReq;
	assign loadResult = (state == S_IDLE) && haveInstr;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			haveInstr <= 1'b0;
			inAck <= 1'b0;
			outReq <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (loadInstr)
						haveInstr <= 1'b1;
					// Decode has had a full cycle so both sides are told at once
					if (loadResult)
					begin
						haveInstr <= 1'b0;
						inAck <= 1'b1;
						outReq <= 1'b1;
						state <= S_HOLD;
					end
				end
				S_HOLD:
				begin
					// Each side closes on its own schedule
					if (!inReq)
						inAck <= 1'b0;
					if (outAck)
						outReq <= 1'b0;
					// Move on once both lines are low or go low on this edge
					if ((!inAck || !inReq) && (!outReq || outAck))
						state <= S_DRAIN;
				end
				S_DRAIN:
				begin
					// The consumer still has to release ack before a new word
					if (!outAck)
						state <= S_IDLE;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// ==============================
	// Payload registers
	// ==============================

	// Zeroing rule for illegal opcodes applied on top of the sub-decoders
	always_comb
	begin
		decodeNow = '0;
		if (bus.illegal)
		begin
			decodeNow.op = OP_NOP;
			decodeNow.illegal = 1'b1;
		end
		else
		begin
			decodeNow.op = bus.instr.opcode;
			decodeNow.rt = bus.rt;
			decodeNow.ra = bus.ra;
			decodeNow.rb = bus.rb;
			decodeNow.imm = bus.imm;
			decodeNow.hasImm = bus.hasImm;
			decodeNow.swap = bus.swap;
			decodeNow.isLoad = bus.isLoad;
			decodeNow.isStore = bus.isStore;
			decodeNow.writesRt = bus.writesRt;
		end
	end

	// The instruction stays put until the next word is accepted
	// and decoded holds steady while outReq is high
	always_ff @(posedge clk)
	begin
		if (loadInstr)
			bus.instr <= instr;
		if (loadResult)
			decoded <= decodeNow;
	end

endmodule

// File: source/decodeSwap.sv
`timescale 1ns/1ps

// Operand swap decoder
// Bit 22 asks for the immediate to be used as operand A instead of B
// A reversed subtract such as SUBFI relies on this
module decodeSwap import quplsPkg::*;
(
	decodeBus.swapDec bus
);

	// Set when the opcode belongs to a group where bit 22 has meaning
	logic swapAllowed;

	// The swap groups are exactly the immediate-bearing groups
	// Jump, loads and stores count too since they add an immediate offset
	assign swapAllowed = fnImmForm(bus.instr.opcode);

	// Register forms and illegal codes never swap
	// Bit 22 there is part of an unused field and must not leak out
	always_comb
	begin
		if (swapAllowed)
			bus.swap = bus.instr.swapBit;
		else
			bus.swap = 1'b0;
	end

endmodule

// File: source/decodeTop.sv
`timescale 1ns/1ps

// Top level of the decode stage
// Fetch connects on the in side and issue on the out side
module decodeTop import quplsPkg::*;
(
	// Clock and synchronous reset
	input  logic         clk,
	input  logic         reset,

	// ==============================
	// Fetch side
	// ==============================

	// Instruction word must stay stable from inReq high until inAck high
	input  logic         inReq,
	output logic         inAck,
	input  instruction_t instr,

	// ==============================
	// Issue side
	// ==============================

	// Each rise of outReq marks one new decoded result
	output logic         outReq,
	input  logic         outAck,
	output decoded_t     decoded
);

	// Single decode lane
	decodeStage stage0
	(
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inAck(inAck),
		.instr(instr),
		.outReq(outReq),
		.outAck(outAck),
		.decoded(decoded)
	);

endmodule

// File: source/quplsPkg.sv
package quplsPkg;

// ==============================
// Opcodes
// ==============================

// Seven bit major opcodes with fixed codes
// Any code not listed here decodes as illegal
typedef enum logic [6:0] {
	OP_NOP   = 7'd0,
	OP_ADD   = 7'd4,
	OP_SUB   = 7'd5,
	OP_AND   = 7'd8,
	OP_OR    = 7'd9,
	OP_ADDI  = 7'd32,
	OP_CMPI  = 7'd33,
	OP_MULI  = 7'd34,
	OP_DIVI  = 7'd35,
	OP_SUBFI = 7'd37,
	OP_ANDI  = 7'd40,
	OP_ORI   = 7'd41,
	OP_EORI  = 7'd42,
	OP_JSR   = 7'd48,
	OP_LDB   = 7'd64,
	OP_LDBU  = 7'd65,
	OP_LDW   = 7'd66,
	OP_LDWU  = 7'd67,
	OP_LDT   = 7'd68,
	OP_LDTU  = 7'd69,
	OP_LDO   = 7'd70,
	OP_CACHE = 7'd71,
	OP_STB   = 7'd80,
	OP_STW   = 7'd81,
	OP_STT   = 7'd82,
	OP_STO   = 7'd83
} opcode_t;

// ==============================
// Instruction and result formats
// ==============================

// Immediate forms reuse the rb bits as the low part of the immediate
typedef struct packed {
	logic [8:0] immHi;
	logic       swapBit;
	logic [4:0] rb;
	logic [4:0] ra;
	logic [4:0] rt;
	opcode_t    opcode;
} instruction_t;

// Width of the immediate built from immHi and rb
localparam int IMM_BITS = 14;

// Everything the issue side needs from one instruction
typedef struct packed {
	opcode_t     op;
	logic [4:0]  rt;
	logic [4:0]  ra;
	logic [4:0]  rb;
	logic [31:0] imm;
	logic        hasImm;
	logic        swap;
	logic        isLoad;
	logic        isStore;
	logic        writesRt;
	logic        illegal;
} decoded_t;

// States of the stage that sequence both four-phase handshakes
typedef enum logic [1:0] {
	S_IDLE,
	S_HOLD,
	S_DRAIN
} hsState_t;

// True for the groups that carry an immediate
// These are the same groups in which bit 22 can swap the operands
function automatic logic fnImmForm(input opcode_t op);
	case (op)
		OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI, OP_SUBFI,
		OP_ANDI, OP_ORI, OP_EORI, OP_JSR,
		OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_CACHE,
		OP_STB, OP_STW, OP_STT, OP_STO:
			fnImmForm = 1'b1;
		default:
			fnImmForm = 1'b0;
	endcase
endfunction

endpackage

// File: tests/decodeStage_asserts.sv
`timescale 1ns/1ps

// Handshake properties of the decode stage
module decodeStage_asserts import quplsPkg::*;
(
	input logic     clk,
	input logic     reset,
	input logic     inReq,
	input logic     inAck,
	input logic     outReq,
	input logic     outAck,
	input decoded_t decoded,
	input hsState_t state
);

	// A result stays offered until the consumer takes it
	assert property (@(posedge clk) disable iff (reset) outReq && !outAck |=> outReq)
		else $error("outReq dropped before outAck was seen");

	// The issue side may sample decoded at any point while outReq is high
	assert property (@(posedge clk) disable iff (reset) outReq |=> $stable(decoded))
		else $error("decoded changed while outReq was high");

	// Ack answers a request and never rises on its own
	// The request is judged on the edge that raised ack
	assert property (@(posedge clk) disable iff (reset) $rose(inAck) |-> $past(inReq))
		else $error("inAck rose without inReq");

	// Reset clears both outgoing lines
	assert property (@(posedge clk) reset |=> !inAck && !outReq)
		else $error("inAck or outReq high after reset");

	// Idle means both handshakes are closed
	assert property (@(posedge clk) disable iff (reset) state == S_IDLE |-> !inAck && !outReq)
		else $error("handshake line high in S_IDLE");

endmodule

bind decodeStage decodeStage_asserts asserts0
(
	.clk(clk),
	.reset(reset),
	.inReq(inReq),
	.inAck(inAck),
	.outReq(outReq),
	.outAck(outAck),
	.decoded(decoded),
	.state(state)
);

// File: tests/decodeTb.sv
`timescale 1ns/1ps

// Testbench for the decode stage behind decodeTop
module decodeTb import quplsPkg::*;
();

	// ==============================
	// Constants and state
	// ==============================

	localparam int TIMEOUT_CYCLES = 200;
	localparam int SEL_INACK = 0;
	localparam int SEL_OUTREQ = 1;

	// Opcode groups used by the reference decoder
	localparam int G_NOP = 0;
	localparam int G_REG = 1;
	localparam int G_ARITH = 2;
	localparam int G_CMP = 3;
	localparam int G_JSR = 4;
	localparam int G_LOAD = 5;
	localparam int G_CACHE = 6;
	localparam int G_STORE = 7;
	localparam int G_ILLEGAL = 8;

	logic clk;
	logic reset;
	logic inReq;
	logic inAck;
	instruction_t instr;
	logic outReq;
	logic outAck;
	decoded_t decoded;

	// Words still to send, and words sent but not yet checked
	instruction_t pending[$];
	instruction_t sentQueue[$];

	int errorCount;
	int resultCount;
	int testsPassed;
	int testsFailed;
	logic timedOut;
	logic outReqSeen;

	decodeTop dut0
	(
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inAck(inAck),
		.instr(instr),
		.outReq(outReq),
		.outAck(outAck),
		.decoded(decoded)
	);

	always #5 clk = ~clk;

	// ==============================
	// Reference decoder
	// ==============================

	function automatic int groupOf(input opcode_t op);
		case (op)
			OP_NOP: return G_NOP;
			OP_ADD, OP_SUB, OP_AND, OP_OR: return G_REG;
			OP_ADDI, OP_MULI, OP_DIVI, OP_SUBFI, OP_ANDI, OP_ORI, OP_EORI: return G_ARITH;
			OP_CMPI: return G_CMP;
			OP_JSR: return G_JSR;
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO: return G_LOAD;
			OP_CACHE: return G_CACHE;
			OP_STB, OP_STW, OP_STT, OP_STO: return G_STORE;
			default: return G_ILLEGAL;
		endcase
	endfunction

	// Everything past the register forms carries an immediate
	function automatic logic carriesImm(input int g);
		return g != G_NOP && g != G_REG && g != G_ILLEGAL;
	endfunction

	function automatic decoded_t refDecode(input instruction_t w);
		decoded_t d;
		int g;
		d = '0;
		g = groupOf(w.opcode);
		if (g == G_ILLEGAL)
		begin
			d.op = OP_NOP;
			d.illegal = 1'b1;
		end
		else
		begin
			d.op = w.opcode;
			d.hasImm = carriesImm(g);
			d.swap = d.hasImm ? w.swapBit : 1'b0;
			// The 14 bit field is immHi over rb with its sign in bit 31
			if (d.hasImm)
				d.imm = {{18{w.immHi[8]}}, w.immHi, w.rb};
			d.rb = (g == G_REG) ? w.rb : 5'd0;
			d.ra = (g == G_NOP) ? 5'd0 : w.ra;
			d.writesRt = g == G_REG || g == G_ARITH || g == G_JSR || g == G_LOAD;
			d.isLoad = g == G_LOAD || g == G_CACHE;
			d.isStore = g == G_STORE;
			d.rt = d.writesRt ? w.rt : 5'd0;
		end
		return d;
	endfunction

	// Walks the enum so the legal list follows the package
	function automatic opcode_t nthLegal(input int n);
		opcode_t op;
		op = op.first();
		repeat (n)
			op = op.next();
		return op;
	endfunction

	// ==============================
	// Checking
	// ==============================

	function automatic void checkField(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Error at %0t: %s expected %h actual %h", $time, name, expected, actual);
			errorCount++;
		end
	endfunction

	function automatic void compareResult();
		decoded_t exp;
		if (sentQueue.size() == 0)
		begin
			$display("Result at %0t arrived with no word outstanding", $time);
			errorCount++;
		end
		else
		begin
			exp = refDecode(sentQueue.pop_front());
			checkField("decoded.op", 32'(exp.op), 32'(decoded.op));
			checkField("decoded.rt", 32'(exp.rt), 32'(decoded.rt));
			checkField("decoded.ra", 32'(exp.ra), 32'(decoded.ra));
			checkField("decoded.rb", 32'(exp.rb), 32'(decoded.rb));
			checkField("decoded.imm", exp.imm, decoded.imm);
			checkField("decoded.hasImm", 32'(exp.hasImm), 32'(decoded.hasImm));
			checkField("decoded.swap", 32'(exp.swap), 32'(decoded.swap));
			checkField("decoded.isLoad", 32'(exp.isLoad), 32'(decoded.isLoad));
			checkField("decoded.isStore", 32'(exp.isStore), 32'(decoded.isStore));
			checkField("decoded.writesRt", 32'(exp.writesRt), 32'(decoded.writesRt));
			checkField("decoded.illegal", 32'(exp.illegal), 32'(decoded.illegal));
		end
		resultCount++;
	endfunction

	// Each rise of outReq is one result, seen with pre-edge values
	always @(posedge clk)
	begin
		if (reset)
			outReqSeen = 1'b0;
		else
		begin
			if (outReq && !outReqSeen)
				compareResult();
			outReqSeen = outReq;
		end
	end

	// ==============================
	// Handshake drivers
	// ==============================

	// Returns one ns after the edge on which the line shows the level
	task automatic waitFor(input int sel, input logic level, input string what);
		int cycles;
		cycles = 0;
		while (!timedOut && ((sel == SEL_INACK) ? inAck : outReq) !== level)
		begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles >= TIMEOUT_CYCLES)
			begin
				$display("Timeout at %0t: %s did not happen within %0d cycles",
					$time, what, cycles);
				timedOut = 1'b1;
			end
		end
	endtask

	task automatic produceAll();
		instruction_t w;
		while (pending.size() > 0 && !timedOut)
		begin
			w = pending.pop_front();
			instr = w;
			inReq = 1'b1;
			sentQueue.push_back(w);
			waitFor(SEL_INACK, 1'b1, "inAck rising");
			inReq = 1'b0;
			waitFor(SEL_INACK, 1'b0, "inAck falling");
		end
	endtask

	task automatic consumeAll(input int count, input int ackDelay, input bit randomAck);
		int delay;
		for (int i = 0; i < count && !timedOut; i++)
		begin
			waitFor(SEL_OUTREQ, 1'b1, "outReq rising");
			delay = randomAck ? int'($urandom_range(0, 8)) : ackDelay;
			repeat (delay)
			begin
				@(posedge clk);
				#1;
			end
			outAck = 1'b1;
			waitFor(SEL_OUTREQ, 1'b0, "outReq falling");
			outAck = 1'b0;
		end
	endtask

	task automatic reportTest(input string name, input int count, input int errorsBefore);
		if (errorCount == errorsBefore && !timedOut)
		begin
			testsPassed++;
			$display("Test %s: %0d words, passed", name, count);
		end
		else
		begin
			testsFailed++;
			$display("Test %s: %0d words, %0d errors, failed", name, count,
				errorCount - errorsBefore);
		end
	endtask

	task automatic runTest(input string name, input int ackDelay, input bit randomAck);
		int count;
		int errorsBefore;
		count = pending.size();
		errorsBefore = errorCount;
		resultCount = 0;
		fork
			produceAll();
			consumeAll(count, ackDelay, randomAck);
		join
		if (!timedOut && (resultCount != count || sentQueue.size() != 0))
		begin
			$display("Test %s: got %0d results for %0d words", name, resultCount, count);
			errorCount++;
		end
		sentQueue.delete();
		reportTest(name, count, errorsBefore);
	endtask

	// ==============================
	// Stimulus
	// ==============================

	task automatic checkReset();
		int errorsBefore;
		errorsBefore = errorCount;
		for (int i = 0; i < 5; i++)
		begin
			@(posedge clk);
			#1;
			checkField("inAck", 32'd0, 32'(inAck));
			checkField("outReq", 32'd0, 32'(outReq));
			// Three cycles held, then two more checked with reset low
			if (i == 2)
				reset = 1'b0;
		end
		reportTest("reset", 0, errorsBefore);
	endtask

	// Swap groups and register forms, each with bit 22 set then clear
	task automatic queueSwapWords();
		instruction_t w;
		for (int n = 0; n < 26; n++)
		begin
			for (int sb = 1; sb >= 0; sb--)
			begin
				w = $urandom;
				w.opcode = nthLegal(n);
				w.swapBit = sb[0];
				pending.push_back(w);
			end
		end
	endtask

	// Positive, negative, largest and smallest 14 bit immediates
	task automatic queueImmWords();
		instruction_t w;
		logic [13:0] immVal;
		for (int n = 0; n < 26; n++)
		begin
			if (carriesImm(groupOf(nthLegal(n))))
			begin
				for (int k = 0; k < 4; k++)
				begin
					case (k)
						0: immVal = 14'h0123;
						1: immVal = 14'h3e5c;
						2: immVal = 14'h1fff;
						default: immVal = 14'h2000;
					endcase
					w = $urandom;
					w.opcode = nthLegal(n);
					w.immHi = immVal[13:5];
					w.rb = immVal[4:0];
					pending.push_back(w);
				end
			end
		end
	endtask

	task automatic queueMixedWords(input int count, input bit illegalOnly);
		instruction_t w;
		for (int c = 0; c < count; c++)
		begin
			w = $urandom;
			if (illegalOnly)
				w.opcode = opcode_t'(c[6:0]);
			else if ($urandom_range(0, 3) != 0)
				w.opcode = nthLegal(int'($urandom_range(0, 25)));
			if (!illegalOnly || groupOf(w.opcode) == G_ILLEGAL)
				pending.push_back(w);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		inReq = 1'b0;
		outAck = 1'b0;
		instr = '0;
		errorCount = 0;
		resultCount = 0;
		testsPassed = 0;
		testsFailed = 0;
		timedOut = 1'b0;
		outReqSeen = 1'b0;
		void'($urandom(32'h0a9e_db5a));
		checkReset();
		queueSwapWords();
		runTest("swap", 0, 1'b0);
		queueImmWords();
		runTest("immediate", 1, 1'b0);
		// Every legal opcode twice with random fields
		for (int n = 0; n < 52; n++)
		begin
			pending.push_back($urandom);
			pending[n].opcode = nthLegal(n % 26);
		end
		runTest("registers", 2, 1'b0);
		queueMixedWords(128, 1'b1);
		runTest("illegal", 3, 1'b0);
		queueMixedWords(300, 1'b0);
		runTest("random", 0, 1'b1);
		$display("Tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
		if (testsFailed == 0 && errorCount == 0 && !timedOut)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: vlog.f
source/quplsPkg.sv
source/decodeBus.sv
source/decodeSwap.sv
source/decodeImm.sv
source/decodeRegs.sv
source/decodeStage.sv
source/decodeTop.sv
tests/decodeStage_asserts.sv
tests/decodeTb.sv
